/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// machine widths and reset vector
`define RV_XLEN      64
`define RV_RESET_PC  64'h0000_0000_8000_0000
`define RV_NREGS     32
`define RV_ILEN      32

// major opcodes
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_LUI    7'b0110111
`define RV_OP_BRANCH 7'b1100011

// funct3 for alu ops
`define RV_F3_ADD    3'b000
`define RV_F3_XOR    3'b100
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111

// funct3 for branches
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001

// funct7 splits add from sub
`define RV_F7_BASE   7'b0000000
`define RV_F7_SUB    7'b0100000

`endif

/* rv_pkg.sv */
`include "rv_cfg.svh"

package rv_pkg;

	// data word and instruction address
	typedef logic [`RV_XLEN-1:0] xlen_t;
	typedef logic [`RV_XLEN-1:0] pc_t;

	// raw instruction word
	typedef logic [`RV_ILEN-1:0] inst_t;

	// register index
	typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

	// alu operations, pass_b carries the lui immediate
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

endpackage

/* rv_fetch.sv */
`include "rv_cfg.svh"

module rv_fetch
	import rv_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n_i,
	input  logic  ex_redirect_i,
	input  pc_t   ex_target_i,
	output pc_t   imem_addr_o,
	input  inst_t imem_data_i,
	output logic  id_valid_o,
	output pc_t   id_pc_o,
	output inst_t id_inst_o
);

	localparam pc_t PC_STEP = pc_t'(`RV_ILEN / 8);

	pc_t pc_q;
	pc_t pc_d;

	// taken branch in execute wins over sequential fetch
	assign pc_d = ex_redirect_i ? ex_target_i : pc_q + PC_STEP;

	// rom answers in the same cycle
	assign imem_addr_o = pc_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q       <= `RV_RESET_PC;
			id_valid_o <= 1'b0;
		end else begin
			pc_q       <= pc_d;
			// word fetched under a redirect is on the wrong path
			id_valid_o <= !ex_redirect_i;
		end
	end

	// fetch/decode payload
	always_ff @(posedge clk) begin
		id_pc_o   <= pc_q;
		id_inst_o <= imem_data_i;
	end

	// branch targets must keep the fetch word aligned
	a_imem_aligned : assert property (
		@(posedge clk) disable iff (!rst_n_i)
		imem_addr_o[1:0] == 2'b00
	) else $error("misaligned fetch address %h", imem_addr_o);

endmodule

/* rv_regfile.sv */
`include "rv_cfg.svh"

module rv_regfile
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	input  reg_addr_t rs1_addr_i,
	input  reg_addr_t rs2_addr_i,
	output xlen_t     rs1_data_o,
	output xlen_t     rs2_data_o,
	input  logic      we_i,
	input  reg_addr_t rd_addr_i,
	input  xlen_t     rd_data_i
);

	// x0 has no storage
	xlen_t regs_q [1:`RV_NREGS-1];

	always_ff @(posedge clk) begin
		if (we_i && rd_addr_i != '0) begin
			regs_q[rd_addr_i] <= rd_data_i;
		end
	end

	// read with same-cycle write-through
	function automatic xlen_t read_reg(input reg_addr_t addr);
		xlen_t val;
		if (addr == '0) begin
			val = '0;
		end else if (we_i && addr == rd_addr_i) begin
			val = rd_data_i;
		end else begin
			val = regs_q[addr];
		end
		return val;
	endfunction

	always_comb begin
		rs1_data_o = read_reg(rs1_addr_i);
		rs2_data_o = read_reg(rs2_addr_i);
	end

endmodule

/* rv_decode.sv */
`include "rv_cfg.svh"

module rv_decode
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      flush_i,
	input  logic      id_valid_i,
	input  pc_t       id_pc_i,
	input  inst_t     id_inst_i,
	input  logic      wb_we_i,
	input  reg_addr_t wb_rd_i,
	input  xlen_t     wb_data_i,
	output logic      ex_valid_o,
	output pc_t       ex_pc_o,
	output inst_t     ex_inst_o,
	output reg_addr_t ex_rs1_o,
	output reg_addr_t ex_rs2_o,
	output xlen_t     ex_rs1_data_o,
	output xlen_t     ex_rs2_data_o,
	output xlen_t     ex_imm_o,
	output alu_op_e   ex_alu_op_o,
	output logic      ex_use_imm_o,
	output logic      ex_branch_o,
	output logic      ex_branch_ne_o,
	output reg_addr_t ex_rd_o,
	output logic      ex_rd_we_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	reg_addr_t  rd;
	xlen_t      imm_i;
	xlen_t      imm_u;
	xlen_t      imm_b;
	xlen_t      rs1_data;
	xlen_t      rs2_data;

	xlen_t      imm;
	alu_op_e    alu_op;
	logic       use_imm;
	logic       branch;
	logic       branch_ne;
	logic       rd_we;

	assign opcode = id_inst_i[6:0];
	assign rd     = id_inst_i[11:7];
	assign funct3 = id_inst_i[14:12];
	assign rs1    = id_inst_i[19:15];
	assign rs2    = id_inst_i[24:20];
	assign funct7 = id_inst_i[31:25];

	// sign-extended immediates
	assign imm_i = {{(`RV_XLEN-12){id_inst_i[31]}}, id_inst_i[31:20]};
	assign imm_u = {{(`RV_XLEN-32){id_inst_i[31]}}, id_inst_i[31:12], 12'b0};
	assign imm_b = {{(`RV_XLEN-13){id_inst_i[31]}}, id_inst_i[31], id_inst_i[7],
		id_inst_i[30:25], id_inst_i[11:8], 1'b0};

	always_comb begin
		imm       = '0;
		alu_op    = ALU_ADD;
		use_imm   = 1'b0;
		branch    = 1'b0;
		branch_ne = 1'b0;
		rd_we     = 1'b0;
		case (opcode)
			`RV_OP_IMM: begin
				imm     = imm_i;
				use_imm = 1'b1;
				rd_we   = 1'b1;
				case (funct3)
					`RV_F3_ADD: alu_op = ALU_ADD;
					`RV_F3_AND: alu_op = ALU_AND;
					`RV_F3_OR:  alu_op = ALU_OR;
					`RV_F3_XOR: alu_op = ALU_XOR;
					default:    rd_we  = 1'b0;
				endcase
			end
			`RV_OP_REG: begin
				rd_we = 1'b1;
				case ({funct7, funct3})
					{`RV_F7_BASE, `RV_F3_ADD}: alu_op = ALU_ADD;
					{`RV_F7_SUB, `RV_F3_ADD}:  alu_op = ALU_SUB;
					{`RV_F7_BASE, `RV_F3_AND}: alu_op = ALU_AND;
					{`RV_F7_BASE, `RV_F3_OR}:  alu_op = ALU_OR;
					{`RV_F7_BASE, `RV_F3_XOR}: alu_op = ALU_XOR;
					default:                   rd_we  = 1'b0;
				endcase
			end
			`RV_OP_LUI: begin
				imm     = imm_u;
				use_imm = 1'b1;
				alu_op  = ALU_PASS_B;
				rd_we   = 1'b1;
			end
			`RV_OP_BRANCH: begin
				imm = imm_b;
				// other branch conditions fall through as no-ops
				case (funct3)
					`RV_F3_BEQ: branch = 1'b1;
					`RV_F3_BNE: begin
						branch    = 1'b1;
						branch_ne = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	rv_regfile u_regfile (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rs1_addr_i (rs1),
		.rs2_addr_i (rs2),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.we_i       (wb_we_i),
		.rd_addr_i  (wb_rd_i),
		.rd_data_i  (wb_data_i)
	);

	// decode/execute control
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_valid_o     <= 1'b0;
			ex_branch_o    <= 1'b0;
			ex_branch_ne_o <= 1'b0;
			ex_rd_we_o     <= 1'b0;
		end else begin
			ex_valid_o     <= id_valid_i && !flush_i;
			ex_branch_o    <= branch;
			ex_branch_ne_o <= branch_ne;
			ex_rd_we_o     <= rd_we;
		end
	end

	// decode/execute payload
	always_ff @(posedge clk) begin
		ex_pc_o       <= id_pc_i;
		ex_inst_o     <= id_inst_i;
		ex_rs1_o      <= rs1;
		ex_rs2_o      <= rs2;
		ex_rs1_data_o <= rs1_data;
		ex_rs2_data_o <= rs2_data;
		ex_imm_o      <= imm;
		ex_alu_op_o   <= alu_op;
		ex_use_imm_o  <= use_imm;
		ex_rd_o       <= rd;
	end

endmodule

/* rv_exe.sv */
module rv_exe
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      ex_valid_i,
	input  pc_t       ex_pc_i,
	input  inst_t     ex_inst_i,
	input  reg_addr_t ex_rs1_i,
	input  reg_addr_t ex_rs2_i,
	input  xlen_t     ex_rs1_data_i,
	input  xlen_t     ex_rs2_data_i,
	input  xlen_t     ex_imm_i,
	input  alu_op_e   ex_alu_op_i,
	input  logic      ex_use_imm_i,
	input  logic      ex_branch_i,
	input  logic      ex_branch_ne_i,
	input  reg_addr_t ex_rd_i,
	input  logic      ex_rd_we_i,
	output logic      redirect_o,
	output pc_t       target_o,
	output logic      wb_valid_o,
	output pc_t       wb_pc_o,
	output inst_t     wb_inst_o,
	output logic      wb_we_o,
	output reg_addr_t wb_rd_o,
	output xlen_t     wb_data_o
);

	xlen_t src_a;
	xlen_t src_b;
	xlen_t op_b;
	xlen_t alu_res;
	logic  taken;

	// bypass from the instruction now in writeback
	function automatic xlen_t fwd_src(
		input reg_addr_t idx,
		input xlen_t     dec_data,
		input logic      wb_we,
		input reg_addr_t wb_rd,
		input xlen_t     wb_data
	);
		xlen_t val;
		if (wb_we && wb_rd != '0 && wb_rd == idx) begin
			val = wb_data;
		end else begin
			val = dec_data;
		end
		return val;
	endfunction

	assign src_a = fwd_src(ex_rs1_i, ex_rs1_data_i, wb_we_o, wb_rd_o, wb_data_o);
	assign src_b = fwd_src(ex_rs2_i, ex_rs2_data_i, wb_we_o, wb_rd_o, wb_data_o);

	assign op_b = ex_use_imm_i ? ex_imm_i : src_b;

	always_comb begin
		case (ex_alu_op_i)
			ALU_ADD:    alu_res = src_a + op_b;
			ALU_SUB:    alu_res = src_a - op_b;
			ALU_AND:    alu_res = src_a & op_b;
			ALU_OR:     alu_res = src_a | op_b;
			ALU_XOR:    alu_res = src_a ^ op_b;
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = '0;
		endcase
	end

	// beq on equal, bne on not equal
	assign taken = (src_a == src_b) ^ ex_branch_ne_i;

	assign redirect_o = ex_valid_i && ex_branch_i && taken;
	assign target_o   = ex_pc_i + ex_imm_i;

	// execute/writeback control
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_valid_o <= 1'b0;
			wb_we_o    <= 1'b0;
		end else begin
			wb_valid_o <= ex_valid_i;
			wb_we_o    <= ex_valid_i && ex_rd_we_i;
		end
	end

	// execute/writeback payload
	always_ff @(posedge clk) begin
		wb_pc_o   <= ex_pc_i;
		wb_inst_o <= ex_inst_i;
		wb_rd_o   <= ex_rd_i;
		wb_data_o <= alu_res;
	end

	// the flush kills whatever would follow in execute
	a_single_redirect : assert property (
		@(posedge clk) disable iff (!rst_n_i)
		redirect_o |=> !redirect_o
	) else $error("redirect held for two cycles");

endmodule

/* rv_core.sv */
module rv_core
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	output pc_t       imem_addr_o,
	input  inst_t     imem_data_i,
	output logic      retire_valid_o,
	output pc_t       retire_pc_o,
	output inst_t     retire_inst_o,
	output logic      retire_we_o,
	output reg_addr_t retire_rd_o,
	output xlen_t     retire_data_o
);

	// fetch to decode
	logic      id_valid;
	pc_t       id_pc;
	inst_t     id_inst;

	// decode to execute
	logic      ex_valid;
	pc_t       ex_pc;
	inst_t     ex_inst;
	reg_addr_t ex_rs1;
	reg_addr_t ex_rs2;
	xlen_t     ex_rs1_data;
	xlen_t     ex_rs2_data;
	xlen_t     ex_imm;
	alu_op_e   ex_alu_op;
	logic      ex_use_imm;
	logic      ex_branch;
	logic      ex_branch_ne;
	reg_addr_t ex_rd;
	logic      ex_rd_we;

	// branch redirect
	logic      ex_redirect;
	pc_t       ex_target;

	// writeback
	logic      wb_valid;
	pc_t       wb_pc;
	inst_t     wb_inst;
	logic      wb_we;
	reg_addr_t wb_rd;
	xlen_t     wb_data;

	rv_fetch u_fetch (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.ex_redirect_i (ex_redirect),
		.ex_target_i   (ex_target),
		.imem_addr_o   (imem_addr_o),
		.imem_data_i   (imem_data_i),
		.id_valid_o    (id_valid),
		.id_pc_o       (id_pc),
		.id_inst_o     (id_inst)
	);

	// redirect also squashes the instruction in decode
	rv_decode u_decode (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.flush_i        (ex_redirect),
		.id_valid_i     (id_valid),
		.id_pc_i        (id_pc),
		.id_inst_i      (id_inst),
		.wb_we_i        (wb_we),
		.wb_rd_i        (wb_rd),
		.wb_data_i      (wb_data),
		.ex_valid_o     (ex_valid),
		.ex_pc_o        (ex_pc),
		.ex_inst_o      (ex_inst),
		.ex_rs1_o       (ex_rs1),
		.ex_rs2_o       (ex_rs2),
		.ex_rs1_data_o  (ex_rs1_data),
		.ex_rs2_data_o  (ex_rs2_data),
		.ex_imm_o       (ex_imm),
		.ex_alu_op_o    (ex_alu_op),
		.ex_use_imm_o   (ex_use_imm),
		.ex_branch_o    (ex_branch),
		.ex_branch_ne_o (ex_branch_ne),
		.ex_rd_o        (ex_rd),
		.ex_rd_we_o     (ex_rd_we)
	);

	rv_exe u_exe (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.ex_valid_i     (ex_valid),
		.ex_pc_i        (ex_pc),
		.ex_inst_i      (ex_inst),
		.ex_rs1_i       (ex_rs1),
		.ex_rs2_i       (ex_rs2),
		.ex_rs1_data_i  (ex_rs1_data),
		.ex_rs2_data_i  (ex_rs2_data),
		.ex_imm_i       (ex_imm),
		.ex_alu_op_i    (ex_alu_op),
		.ex_use_imm_i   (ex_use_imm),
		.ex_branch_i    (ex_branch),
		.ex_branch_ne_i (ex_branch_ne),
		.ex_rd_i        (ex_rd),
		.ex_rd_we_i     (ex_rd_we),
		.redirect_o     (ex_redirect),
		.target_o       (ex_target),
		.wb_valid_o     (wb_valid),
		.wb_pc_o        (wb_pc),
		.wb_inst_o      (wb_inst),
		.wb_we_o        (wb_we),
		.wb_rd_o        (wb_rd),
		.wb_data_o      (wb_data)
	);

	// retire port mirrors the writeback register
	assign retire_valid_o = wb_valid;
	assign retire_pc_o    = wb_pc;
	assign retire_inst_o  = wb_inst;
	assign retire_we_o    = wb_we;
	assign retire_rd_o    = wb_rd;
	assign retire_data_o  = wb_data;

endmodule

/* tb_rv_core.sv */
`include "rv_cfg.svh"

module tb_rv_core
	import rv_pkg::*;
();

	localparam int    PROG_MAX       = 64;
	localparam int    TIMEOUT_CYCLES = 20;
	localparam int    LCG_BLOCK      = 8;
	localparam inst_t NOP            = 32'h0000_0013;

	logic      clk;
	logic      rst_n;
	pc_t       imem_addr;
	inst_t     imem_data;
	logic      retire_valid;
	pc_t       retire_pc;
	inst_t     retire_inst;
	logic      retire_we;
	reg_addr_t retire_rd;
	xlen_t     retire_data;

	// program table and expected retire records
	inst_t     prog_inst [PROG_MAX];
	logic      exp_ret   [PROG_MAX];
	logic      exp_we    [PROG_MAX];
	reg_addr_t exp_rd    [PROG_MAX];
	xlen_t     exp_data  [PROG_MAX];
	int        prog_len = 0;

	// architectural register values while building the table
	xlen_t     ref_x [`RV_NREGS];

	int          fetch_cycle [PROG_MAX];
	int          cycle_cnt;
	int          errors;
	int          checks;
	logic [31:0] lcg_state;

	rv_core dut (
		.clk            (clk),
		.rst_n_i        (rst_n),
		.imem_addr_o    (imem_addr),
		.imem_data_i    (imem_data),
		.retire_valid_o (retire_valid),
		.retire_pc_o    (retire_pc),
		.retire_inst_o  (retire_inst),
		.retire_we_o    (retire_we),
		.retire_rd_o    (retire_rd),
		.retire_data_o  (retire_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	function automatic xlen_t rom_index(input pc_t addr);
		return (addr - `RV_RESET_PC) >> 2;
	endfunction

	function automatic pc_t entry_pc(input int idx);
		return `RV_RESET_PC + pc_t'(4 * idx);
	endfunction

	// tightly coupled rom returning nop past the end of the program
	always_comb begin
		if (rom_index(imem_addr) < xlen_t'(prog_len)) begin
			imem_data = prog_inst[rom_index(imem_addr)];
		end else begin
			imem_data = NOP;
		end
	end

	// remember the cycle each address was presented
	always @(negedge clk) begin
		if (rst_n && rom_index(imem_addr) < xlen_t'(PROG_MAX)) begin
			fetch_cycle[rom_index(imem_addr)] = cycle_cnt;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic xlen_t sext12(input logic [11:0] v);
		return {{(`RV_XLEN-12){v[11]}}, v};
	endfunction

	function automatic xlen_t uimm(input logic [19:0] v);
		return {{(`RV_XLEN-32){v[19]}}, v, 12'b0};
	endfunction

	function automatic inst_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd);
		return {imm, rs1, f3, rd, `RV_OP_IMM};
	endfunction

	function automatic inst_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
	endfunction

	function automatic inst_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
		return {imm, rd, `RV_OP_LUI};
	endfunction

	function automatic inst_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
	endfunction

	task automatic add_write(input inst_t inst, input reg_addr_t rd, input xlen_t data);
		prog_inst[prog_len] = inst;
		exp_ret[prog_len]   = 1'b1;
		exp_we[prog_len]    = 1'b1;
		exp_rd[prog_len]    = rd;
		exp_data[prog_len]  = data;
		// x0 keeps reading zero
		if (rd != '0) begin
			ref_x[rd] = data;
		end
		prog_len++;
	endtask

	task automatic add_nowrite(input inst_t inst);
		prog_inst[prog_len] = inst;
		exp_ret[prog_len]   = 1'b1;
		exp_we[prog_len]    = 1'b0;
		exp_rd[prog_len]    = '0;
		exp_data[prog_len]  = '0;
		prog_len++;
	endtask

	task automatic add_flushed(input inst_t inst);
		prog_inst[prog_len] = inst;
		exp_ret[prog_len]   = 1'b0;
		exp_we[prog_len]    = 1'b0;
		exp_rd[prog_len]    = '0;
		exp_data[prog_len]  = '0;
		prog_len++;
	endtask

	task automatic build_program();
		int          r;
		int          k;
		reg_addr_t   src;
		logic [11:0] imm;
		for (r = 0; r < `RV_NREGS; r++) begin
			ref_x[r] = '0;
		end
		add_write(enc_i(12'd5, 0, `RV_F3_ADD, 1), 1, ref_x[0] + 5);
		// back-to-back pairs use the bypass and pairs two apart the write-through
		add_write(enc_i(12'd3, 1, `RV_F3_ADD, 2), 2, ref_x[1] + 3);
		add_write(enc_r(`RV_F7_BASE, 2, 1, `RV_F3_ADD, 3), 3, ref_x[1] + ref_x[2]);
		add_write(enc_r(`RV_F7_SUB, 1, 3, `RV_F3_ADD, 4), 4, ref_x[3] - ref_x[1]);
		add_write(enc_u(20'h12345, 5), 5, uimm(20'h12345));
		add_write(enc_u(20'hfedcb, 6), 6, uimm(20'hfedcb));
		add_write(enc_r(`RV_F7_BASE, 6, 5, `RV_F3_XOR, 7), 7, ref_x[5] ^ ref_x[6]);
		add_write(enc_r(`RV_F7_BASE, 6, 7, `RV_F3_AND, 8), 8, ref_x[7] & ref_x[6]);
		add_write(enc_r(`RV_F7_BASE, 1, 8, `RV_F3_OR, 9), 9, ref_x[8] | ref_x[1]);
		add_write(enc_i(12'hff0, 6, `RV_F3_AND, 10), 10, ref_x[6] & sext12(12'hff0));
		add_write(enc_i(12'h7f0, 1, `RV_F3_OR, 11), 11, ref_x[1] | sext12(12'h7f0));
		add_write(enc_i(12'hfff, 0, `RV_F3_XOR, 12), 12, ref_x[0] ^ sext12(12'hfff));
		// write to x0 shows its sum while readers still see zero
		add_write(enc_i(12'd7, 1, `RV_F3_ADD, 0), 0, ref_x[1] + 7);
		add_write(enc_r(`RV_F7_BASE, 1, 0, `RV_F3_ADD, 13), 13, ref_x[0] + ref_x[1]);
		add_write(enc_i(12'd1, 0, `RV_F3_ADD, 14), 14, ref_x[0] + 1);
		// taken since x1 == x13
		add_nowrite(enc_b(13'd12, 13, 1, `RV_F3_BEQ));
		add_flushed(enc_i(12'd99, 0, `RV_F3_ADD, 15));
		add_flushed(enc_i(12'd77, 0, `RV_F3_ADD, 15));
		// bne falls through as x2 == x4
		add_nowrite(enc_b(13'd12, 4, 2, `RV_F3_BNE));
		add_write(enc_i(12'd1, 2, `RV_F3_ADD, 16), 16, ref_x[2] + 1);
		// taken as x16 != x1
		add_nowrite(enc_b(13'd12, 1, 16, `RV_F3_BNE));
		add_flushed(enc_i(12'd1, 0, `RV_F3_ADD, 17));
		add_flushed(enc_i(12'd2, 0, `RV_F3_ADD, 17));
		// beq falls through as x1 != x2
		add_nowrite(enc_b(13'd8, 2, 1, `RV_F3_BEQ));
		add_write(enc_i(12'hffd, 16, `RV_F3_ADD, 18), 18, ref_x[16] + sext12(12'hffd));
		// slt, slli and an all-zero word must leave x1 alone
		add_nowrite(enc_r(`RV_F7_BASE, 3, 2, 3'b010, 1));
		add_nowrite(enc_i(12'd4, 2, 3'b001, 1));
		add_nowrite(32'h0000_0000);
		add_write(enc_i(12'd0, 1, `RV_F3_ADD, 20), 20, ref_x[1]);
		// random immediates chained through x21
		for (k = 0; k < LCG_BLOCK; k++) begin
			lcg_state = lcg_next(lcg_state);
			imm = lcg_state[31:20];
			src = (k == 0) ? reg_addr_t'(0) : reg_addr_t'(21);
			if (k % 2 == 0) begin
				add_write(enc_i(imm, src, `RV_F3_ADD, 21), 21, ref_x[src] + sext12(imm));
			end else begin
				add_write(enc_i(imm, src, `RV_F3_XOR, 21), 21, ref_x[src] ^ sext12(imm));
			end
		end
		add_write(enc_r(`RV_F7_BASE, 12, 21, `RV_F3_ADD, 22), 22, ref_x[21] + ref_x[12]);
		add_write(enc_r(`RV_F7_SUB, 21, 22, `RV_F3_ADD, 23), 23, ref_x[22] - ref_x[21]);
	endtask

	task automatic check_value(input xlen_t expected, input xlen_t actual, input string what);
		checks++;
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, expected %h, got %h",
				$time, what, expected, actual);
			errors++;
		end
	endtask

	task automatic wait_retire(output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < TIMEOUT_CYCLES) begin
			@(negedge clk);
			seen = retire_valid;
			n++;
		end
	endtask

	task automatic check_retire(input int idx);
		check_value(entry_pc(idx), retire_pc, $sformatf("entry %0d pc", idx));
		check_value(prog_inst[idx], retire_inst, $sformatf("entry %0d inst", idx));
		check_value(exp_we[idx], retire_we, $sformatf("entry %0d write enable", idx));
		if (exp_we[idx]) begin
			check_value(exp_rd[idx], retire_rd, $sformatf("entry %0d rd", idx));
			check_value(exp_data[idx], retire_data, $sformatf("entry %0d data", idx));
		end
		check_value(3, cycle_cnt - fetch_cycle[idx],
			$sformatf("entry %0d fetch to retire cycles", idx));
	endtask

	initial begin
		int   i;
		logic got;
		rst_n     = 1'b0;
		errors    = 0;
		checks    = 0;
		cycle_cnt = 0;
		lcg_state = 32'hd82c3e93;
		for (i = 0; i < PROG_MAX; i++) begin
			fetch_cycle[i] = -1;
		end
		build_program();

		// reset spans four rising edges
		repeat (3) begin
			@(negedge clk);
			check_value(0, retire_valid, "retire_valid during reset");
			check_value(`RV_RESET_PC, imem_addr, "imem_addr during reset");
		end
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value(0, retire_valid, "retire_valid after reset");
		check_value(`RV_RESET_PC, imem_addr, "imem_addr after reset");

		got = 1'b1;
		i = 0;
		while (got && i < prog_len) begin
			if (exp_ret[i]) begin
				wait_retire(got);
				if (got) begin
					check_retire(i);
				end else begin
					$display("timeout: entry %0d at pc %h never retired", i, entry_pc(i));
					errors++;
				end
			end
			i++;
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_exe.sv
rv_core.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - rv_fetch.sv
      - rv_regfile.sv
      - rv_decode.sv
      - rv_exe.sv
      - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
